//--- include/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// virtual and physical addresses share one width
`define MMU_ADDR_W    32

// data bus width for both slaves and the core
`define MMU_DATA_W    32

// 4 KB pages
`define MMU_PAGE_BITS 12

// fully associative TLB size
`define MMU_TLB_DEPTH 4
`define MMU_TLB_IDX_W 2

`endif

//--- hdl/mmu_pkg.sv
`include "mmu_params.svh"

package mmu_pkg;

    // TLB maintenance operations from the core
    typedef enum logic [1:0] {
        TLB_NOP   = 2'd0,
        TLB_WRITE = 2'd1,  // indexed write
        TLB_READ  = 2'd2,  // indexed read
        TLB_PROBE = 2'd3   // search by vpn
    } tlb_op_e;

    // one TLB entry, 4 KB page granularity
    typedef struct packed {
        logic [`MMU_ADDR_W-`MMU_PAGE_BITS-1:0] vpn;
        logic [`MMU_ADDR_W-`MMU_PAGE_BITS-1:0] pfn;
        logic                                  valid;
        logic                                  uncached;
    } tlb_entry_t;

    // MIPS address space segments
    typedef enum logic [1:0] {
        SEG_KUSEG  = 2'd0,  // mapped, user
        SEG_KSEG0  = 2'd1,  // unmapped, cached unless k0 says otherwise
        SEG_KSEG1  = 2'd2,  // unmapped, uncached
        SEG_KSEG23 = 2'd3   // mapped, kernel
    } seg_e;

    // stage-1 state of the data dispatch pipeline
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WAIT_ADDR = 2'd1,  // request out, no addr_ok yet
        ST_WAIT_DATA = 2'd2   // addr_ok seen, stage 2 still busy
    } stage_e;

endpackage

//--- hdl/xlate_if.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

// one address translation port, answered combinationally
interface xlate_if;

    logic                   req;
    logic [`MMU_ADDR_W-1:0] vaddr;
    logic [`MMU_ADDR_W-1:0] paddr;
    logic                   uncached;
    logic                   miss;     // no valid TLB match for a mapped address

    modport user (
        output req,
        output vaddr,
        input  paddr,
        input  uncached,
        input  miss
    );

    modport xlate (
        input  req,
        input  vaddr,
        output paddr,
        output uncached,
        output miss
    );

endinterface

//--- hdl/dbus_if.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

// split-transaction data bus: req/addr_ok for the address phase, data_ok to finish
interface dbus_if;

    logic                   req;
    logic                   wr;
    logic [`MMU_ADDR_W-1:0] addr;
    logic [`MMU_DATA_W-1:0] wdata;
    logic                   addr_ok;  // request accepted this cycle when req is high
    logic                   data_ok;  // one per accepted request, in order
    logic [`MMU_DATA_W-1:0] rdata;

    modport master (
        output req,
        output wr,
        output addr,
        output wdata,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport slave (
        input  req,
        input  wr,
        input  addr,
        input  wdata,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

//--- hdl/translation_unit.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module translation_unit
    import mmu_pkg::*;
(
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_k0_uncached,
    input  tlb_op_e                    i_tlb_op,
    input  logic [`MMU_TLB_IDX_W-1:0]  i_tlb_index,
    input  tlb_entry_t                 i_tlb_entry,
    output tlb_entry_t                 o_tlb_rd_entry,
    output logic                       o_tlb_probe_hit,
    output logic [`MMU_TLB_IDX_W-1:0]  o_tlb_probe_index,
    xlate_if.xlate                     ifetch,
    xlate_if.xlate                     data
);

    localparam int VPN_W = `MMU_ADDR_W - `MMU_PAGE_BITS;
    localparam int IDX_W = `MMU_TLB_IDX_W;
    localparam int SEG_W = 3;  // top bits that select the kernel segment

    typedef struct packed {
        logic [`MMU_ADDR_W-1:0] paddr;
        logic                   uncached;
        logic                   miss;
    } xlate_res_t;

    logic [VPN_W-1:0]          vpn_q [`MMU_TLB_DEPTH];
    logic [VPN_W-1:0]          pfn_q [`MMU_TLB_DEPTH];
    logic                      unc_q [`MMU_TLB_DEPTH];
    logic [`MMU_TLB_DEPTH-1:0] valid_q;

    logic             probe_hit;
    logic [IDX_W-1:0] probe_idx;
    xlate_res_t       if_res;
    xlate_res_t       d_res;

    function automatic seg_e seg_of(input logic [`MMU_ADDR_W-1:0] vaddr);
        seg_e seg;
        if (!vaddr[`MMU_ADDR_W-1])
            seg = SEG_KUSEG;
        else if (vaddr[`MMU_ADDR_W-2])
            seg = SEG_KSEG23;  // 0xc000_0000 and up
        else if (vaddr[`MMU_ADDR_W-3])
            seg = SEG_KSEG1;
        else
            seg = SEG_KSEG0;
        return seg;
    endfunction

    // shared by both ports, reads the TLB arrays directly
    function automatic xlate_res_t do_xlate(input logic [`MMU_ADDR_W-1:0] vaddr);
        xlate_res_t res;
        logic       hit;
        res.paddr    = {{SEG_W{1'b0}}, vaddr[`MMU_ADDR_W-SEG_W-1:0]};
        res.uncached = 1'b0;
        res.miss     = 1'b0;
        hit          = 1'b0;
        case (seg_of(vaddr))
            SEG_KSEG0: res.uncached = i_k0_uncached;
            SEG_KSEG1: res.uncached = 1'b1;
            default: begin
                for (int i = 0; i < `MMU_TLB_DEPTH; i++) begin
                    if (!hit && valid_q[i] && vpn_q[i] == vaddr[`MMU_ADDR_W-1 -: VPN_W]) begin
                        hit          = 1'b1;  // first match wins
                        res.paddr    = {pfn_q[i], vaddr[`MMU_PAGE_BITS-1:0]};
                        res.uncached = unc_q[i];
                    end
                end
                res.miss = !hit;
            end
        endcase
        return res;
    endfunction

    always_comb begin
        if_res = do_xlate(ifetch.vaddr);
        d_res  = do_xlate(data.vaddr);
    end

    assign ifetch.paddr    = if_res.paddr;
    assign ifetch.uncached = if_res.uncached;
    assign ifetch.miss     = ifetch.req && if_res.miss;
    assign data.paddr      = d_res.paddr;
    assign data.uncached   = d_res.uncached;
    assign data.miss       = data.req && d_res.miss;

    // probe looks at every valid entry, lowest index reported
    always_comb begin
        probe_hit = 1'b0;
        probe_idx = '0;
        for (int i = `MMU_TLB_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && vpn_q[i] == i_tlb_entry.vpn) begin
                probe_hit = 1'b1;
                probe_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_tlb_op == TLB_WRITE) begin
            vpn_q[i_tlb_index] <= i_tlb_entry.vpn;
            pfn_q[i_tlb_index] <= i_tlb_entry.pfn;
            unc_q[i_tlb_index] <= i_tlb_entry.uncached;
        end
    end

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            valid_q <= '0;
        end else if (i_tlb_op == TLB_WRITE) begin
            valid_q[i_tlb_index] <= i_tlb_entry.valid;
        end
    end

    // read and probe results hold until the next such op
    always_ff @(posedge aclk) begin
        if (aresetn) begin
            o_tlb_rd_entry    <= '0;
            o_tlb_probe_hit   <= 1'b0;
            o_tlb_probe_index <= '0;
        end else begin
            case (i_tlb_op)
                TLB_READ: begin
                    o_tlb_rd_entry.vpn      <= vpn_q[i_tlb_index];
                    o_tlb_rd_entry.pfn      <= pfn_q[i_tlb_index];
                    o_tlb_rd_entry.valid    <= valid_q[i_tlb_index];
                    o_tlb_rd_entry.uncached <= unc_q[i_tlb_index];
                end
                TLB_PROBE: begin
                    o_tlb_probe_hit   <= probe_hit;
                    o_tlb_probe_index <= probe_idx;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/dmem_dispatch.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module dmem_dispatch
    import mmu_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    dbus_if.slave    core,
    xlate_if.user    xl,
    dbus_if.master   cached,
    dbus_if.master   uncached
);

    stage_e st1_q;        // stage 1, address phase
    logic   last_done_q;  // stage 2 has seen its data_ok
    logic   last_unc_q;   // stage 2 belongs to the uncached bus

    logic                   fwd;
    logic                   addr_seen;
    logic                   sel_addr_ok;
    logic                   sel_data_ok;
    logic [`MMU_DATA_W-1:0] sel_rdata;
    logic                   last_ready;
    logic                   cur_ready;

    assign xl.req   = core.req;
    assign xl.vaddr = core.addr;

    // a miss never leaves the MMU
    assign fwd       = core.req && !xl.miss;
    assign addr_seen = (st1_q == ST_WAIT_DATA);

    assign sel_addr_ok = xl.uncached ? uncached.addr_ok : cached.addr_ok;
    assign sel_data_ok = last_unc_q ? uncached.data_ok : cached.data_ok;
    assign sel_rdata   = last_unc_q ? uncached.rdata : cached.rdata;

    // stage 2 can take a new access now or in this same cycle
    assign last_ready = last_done_q || core.data_ok;
    assign cur_ready  = fwd && last_ready && (addr_seen || sel_addr_ok);

    assign core.addr_ok = cur_ready;
    assign core.data_ok = !last_done_q && sel_data_ok;
    assign core.rdata   = sel_rdata;

    // stop asking once the slave took the address
    assign cached.req   = fwd && !xl.uncached && !addr_seen;
    assign cached.wr    = core.wr;
    assign cached.addr  = xl.paddr;
    assign cached.wdata = core.wdata;

    assign uncached.req   = fwd && xl.uncached && !addr_seen;
    assign uncached.wr    = core.wr;
    assign uncached.addr  = xl.paddr;
    assign uncached.wdata = core.wdata;

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            st1_q <= ST_IDLE;
        end else if (cur_ready) begin
            st1_q <= ST_IDLE;  // moved on to stage 2
        end else if (!addr_seen) begin
            if (fwd)
                st1_q <= sel_addr_ok ? ST_WAIT_DATA : ST_WAIT_ADDR;
            else
                st1_q <= ST_IDLE;
        end
    end

    // stage 2 starts out finished so the first access can pass
    always_ff @(posedge aclk) begin
        if (aresetn) begin
            last_done_q <= 1'b1;
            last_unc_q  <= 1'b0;
        end else if (cur_ready) begin
            last_done_q <= 1'b0;
            last_unc_q  <= xl.uncached;  // owner of the outstanding access
        end else if (core.data_ok) begin
            last_done_q <= 1'b1;
        end
    end

endmodule

//--- hdl/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top
    import mmu_pkg::*;
(
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_k0_uncached,

    // TLB maintenance
    input  tlb_op_e                    i_tlb_op,
    input  logic [`MMU_TLB_IDX_W-1:0]  i_tlb_index,
    input  tlb_entry_t                 i_tlb_entry,
    output tlb_entry_t                 o_tlb_rd_entry,
    output logic                       o_tlb_probe_hit,
    output logic [`MMU_TLB_IDX_W-1:0]  o_tlb_probe_index,

    // core instruction fetch
    input  logic                       i_imem_req,
    input  logic [`MMU_ADDR_W-1:0]     i_imem_addr,
    output logic                       o_imem_addr_ok,
    output logic                       o_imem_data_ok,
    output logic [`MMU_DATA_W-1:0]     o_imem_rdata,
    output logic                       o_imem_miss,

    // core data
    input  logic                       i_dmem_req,
    input  logic                       i_dmem_wr,
    input  logic [`MMU_ADDR_W-1:0]     i_dmem_addr,
    input  logic [`MMU_DATA_W-1:0]     i_dmem_wdata,
    output logic                       o_dmem_addr_ok,
    output logic                       o_dmem_data_ok,
    output logic [`MMU_DATA_W-1:0]     o_dmem_rdata,
    output logic                       o_dmem_miss,

    // instruction cache
    output logic                       o_icache_req,
    output logic [`MMU_ADDR_W-1:0]     o_icache_addr,
    input  logic                       i_icache_addr_ok,
    input  logic                       i_icache_data_ok,
    input  logic [`MMU_DATA_W-1:0]     i_icache_rdata,

    // data cache
    output logic                       o_dcache_req,
    output logic                       o_dcache_wr,
    output logic [`MMU_ADDR_W-1:0]     o_dcache_addr,
    output logic [`MMU_DATA_W-1:0]     o_dcache_wdata,
    input  logic                       i_dcache_addr_ok,
    input  logic                       i_dcache_data_ok,
    input  logic [`MMU_DATA_W-1:0]     i_dcache_rdata,

    // uncached bus
    output logic                       o_unc_req,
    output logic                       o_unc_wr,
    output logic [`MMU_ADDR_W-1:0]     o_unc_addr,
    output logic [`MMU_DATA_W-1:0]     o_unc_wdata,
    input  logic                       i_unc_addr_ok,
    input  logic                       i_unc_data_ok,
    input  logic [`MMU_DATA_W-1:0]     i_unc_rdata
);

    xlate_if ifetch_xl ();
    xlate_if data_xl ();
    dbus_if  core_bus ();
    dbus_if  dcache_bus ();
    dbus_if  unc_bus ();

    translation_unit tu_i (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .i_k0_uncached     (i_k0_uncached),
        .i_tlb_op          (i_tlb_op),
        .i_tlb_index       (i_tlb_index),
        .i_tlb_entry       (i_tlb_entry),
        .o_tlb_rd_entry    (o_tlb_rd_entry),
        .o_tlb_probe_hit   (o_tlb_probe_hit),
        .o_tlb_probe_index (o_tlb_probe_index),
        .ifetch            (ifetch_xl.xlate),
        .data              (data_xl.xlate)
    );

    // instruction path goes straight to the icache
    assign ifetch_xl.req   = i_imem_req;
    assign ifetch_xl.vaddr = i_imem_addr;
    assign o_imem_miss     = ifetch_xl.miss;
    assign o_icache_req    = i_imem_req && !ifetch_xl.miss;
    assign o_icache_addr   = ifetch_xl.paddr;
    assign o_imem_addr_ok  = i_icache_addr_ok;
    assign o_imem_data_ok  = i_icache_data_ok;
    assign o_imem_rdata    = i_icache_rdata;

    dmem_dispatch dispatch_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .core     (core_bus.slave),
        .xl       (data_xl.user),
        .cached   (dcache_bus.master),
        .uncached (unc_bus.master)
    );

    assign core_bus.req   = i_dmem_req;
    assign core_bus.wr    = i_dmem_wr;
    assign core_bus.addr  = i_dmem_addr;
    assign core_bus.wdata = i_dmem_wdata;
    assign o_dmem_addr_ok = core_bus.addr_ok;
    assign o_dmem_data_ok = core_bus.data_ok;
    assign o_dmem_rdata   = core_bus.rdata;
    assign o_dmem_miss    = data_xl.miss;

    assign o_dcache_req       = dcache_bus.req;
    assign o_dcache_wr        = dcache_bus.wr;
    assign o_dcache_addr      = dcache_bus.addr;
    assign o_dcache_wdata     = dcache_bus.wdata;
    assign dcache_bus.addr_ok = i_dcache_addr_ok;
    assign dcache_bus.data_ok = i_dcache_data_ok;
    assign dcache_bus.rdata   = i_dcache_rdata;

    assign o_unc_req       = unc_bus.req;
    assign o_unc_wr        = unc_bus.wr;
    assign o_unc_addr      = unc_bus.addr;
    assign o_unc_wdata     = unc_bus.wdata;
    assign unc_bus.addr_ok = i_unc_addr_ok;
    assign unc_bus.data_ok = i_unc_data_ok;
    assign unc_bus.rdata   = i_unc_rdata;

endmodule

//--- sim/mem_slave_model.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

// split-transaction slave: random address stalls, data one cycle after acceptance
module mem_slave_model #(
    parameter logic [`MMU_DATA_W-1:0] TAG = '0
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   i_req,
    input  logic [`MMU_ADDR_W-1:0] i_addr,
    output logic                   o_addr_ok,
    output logic                   o_data_ok,
    output logic [`MMU_DATA_W-1:0] o_rdata
);

    logic [31:0] rng_q;
    logic [31:0] rng_next;
    logic [1:0]  stall_q;    // cycles left before the next addr_ok
    int unsigned accept_count;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign rng_next  = xorshift32(rng_q);
    assign o_addr_ok = i_req && (stall_q == 2'd0);

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            rng_q        <= 32'd12412;
            stall_q      <= 2'd0;
            o_data_ok    <= 1'b0;
            o_rdata      <= '0;
            accept_count <= 0;
        end else begin
            o_data_ok <= i_req && o_addr_ok;
            if (i_req && o_addr_ok) begin
                o_rdata      <= i_addr ^ TAG;  // writes are accepted and dropped
                accept_count <= accept_count + 1;
                rng_q        <= rng_next;
                stall_q      <= rng_next[1:0];  // stall applies to the next request
            end else if (i_req && stall_q != 2'd0) begin
                stall_q <= stall_q - 2'd1;
            end
        end
    end

endmodule

//--- sim/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tb
    import mmu_pkg::*;
;

    localparam int                   CLK_PERIOD   = 4;
    localparam int                   RESET_CYCLES = 10;
    localparam int                   N_ACCESSES   = 28;  // every load, store and fetch below
    localparam logic [`MMU_DATA_W-1:0] DC_TAG     = 32'h5A5A_0000;
    localparam logic [`MMU_DATA_W-1:0] UNC_TAG    = 32'hC3C3_0000;
    localparam logic [`MMU_DATA_W-1:0] IC_TAG     = 32'h0F0F_F0F0;

    logic aclk, aresetn, i_k0_uncached;
    tlb_op_e i_tlb_op;
    logic [`MMU_TLB_IDX_W-1:0] i_tlb_index, o_tlb_probe_index;
    tlb_entry_t i_tlb_entry, o_tlb_rd_entry;
    logic o_tlb_probe_hit;
    logic i_imem_req, o_imem_addr_ok, o_imem_data_ok, o_imem_miss;
    logic [`MMU_ADDR_W-1:0] i_imem_addr;
    logic [`MMU_DATA_W-1:0] o_imem_rdata;
    logic i_dmem_req, i_dmem_wr, o_dmem_addr_ok, o_dmem_data_ok, o_dmem_miss;
    logic [`MMU_ADDR_W-1:0] i_dmem_addr;
    logic [`MMU_DATA_W-1:0] i_dmem_wdata, o_dmem_rdata;
    logic o_icache_req, icache_addr_ok, icache_data_ok;
    logic [`MMU_ADDR_W-1:0] o_icache_addr;
    logic [`MMU_DATA_W-1:0] icache_rdata;
    logic o_dcache_req, o_dcache_wr, dcache_addr_ok, dcache_data_ok;
    logic [`MMU_ADDR_W-1:0] o_dcache_addr;
    logic [`MMU_DATA_W-1:0] o_dcache_wdata, dcache_rdata;
    logic o_unc_req, o_unc_wr, unc_addr_ok, unc_data_ok;
    logic [`MMU_ADDR_W-1:0] o_unc_addr;
    logic [`MMU_DATA_W-1:0] o_unc_wdata, unc_rdata;

    mmu_top dut_i (.*,
        .i_icache_addr_ok (icache_addr_ok), .i_icache_data_ok (icache_data_ok),
        .i_icache_rdata   (icache_rdata),   .i_dcache_addr_ok (dcache_addr_ok),
        .i_dcache_data_ok (dcache_data_ok), .i_dcache_rdata   (dcache_rdata),
        .i_unc_addr_ok    (unc_addr_ok),    .i_unc_data_ok    (unc_data_ok),
        .i_unc_rdata      (unc_rdata));

    mem_slave_model #(.TAG(DC_TAG)) dc_model (.aclk, .aresetn, .i_req(o_dcache_req),
        .i_addr(o_dcache_addr), .o_addr_ok(dcache_addr_ok), .o_data_ok(dcache_data_ok),
        .o_rdata(dcache_rdata));

    mem_slave_model #(.TAG(UNC_TAG)) unc_model (.aclk, .aresetn, .i_req(o_unc_req),
        .i_addr(o_unc_addr), .o_addr_ok(unc_addr_ok), .o_data_ok(unc_data_ok),
        .o_rdata(unc_rdata));

    // icache stand-in, always ready
    assign icache_addr_ok = o_icache_req;
    always_ff @(posedge aclk) begin
        if (aresetn) begin
            icache_data_ok <= 1'b0;
            icache_rdata   <= '0;
        end else begin
            icache_data_ok <= o_icache_req;
            if (o_icache_req)
                icache_rdata <= o_icache_addr ^ IC_TAG;
        end
    end

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`MMU_DATA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got, exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // reference model of the unmapped segments
    function automatic seg_e ref_segment(input logic [`MMU_ADDR_W-1:0] va);
        case (va[31:29])
            3'b100:         return SEG_KSEG0;
            3'b101:         return SEG_KSEG1;
            3'b110, 3'b111: return SEG_KSEG23;
            default:        return SEG_KUSEG;
        endcase
    endfunction

    function automatic logic [`MMU_DATA_W-1:0] ref_rdata(input logic [`MMU_ADDR_W-1:0] va);
        logic unc;
        unc = (ref_segment(va) == SEG_KSEG1) || i_k0_uncached;
        return {3'b000, va[28:0]} ^ (unc ? UNC_TAG : DC_TAG);
    endfunction

    // returns at the sample point where the DUT shows addr_ok
    task automatic issue_load(input logic [`MMU_ADDR_W-1:0] va);
        @(negedge aclk);
        i_dmem_req  = 1'b1;
        i_dmem_addr = va;
        #1;
        while (!o_dmem_addr_ok) begin
            @(negedge aclk);
            #1;
        end
    endtask

    task automatic load_check(input logic [`MMU_ADDR_W-1:0] va, input logic exp_unc,
                              input logic [`MMU_ADDR_W-1:0] exp_pa,
                              input logic [`MMU_DATA_W-1:0] exp_data);
        int unsigned dc0, un0;
        dc0 = dc_model.accept_count;
        un0 = unc_model.accept_count;
        issue_load(va);
        check_word(exp_unc ? "o_unc_addr" : "o_dcache_addr",
                   exp_unc ? o_unc_addr : o_dcache_addr, exp_pa);
        check_flag(exp_unc ? "o_unc_wr" : "o_dcache_wr",
                   exp_unc ? o_unc_wr : o_dcache_wr, i_dmem_wr);
        check_word(exp_unc ? "o_unc_wdata" : "o_dcache_wdata",
                   exp_unc ? o_unc_wdata : o_dcache_wdata, i_dmem_wdata);
        @(negedge aclk);
        i_dmem_req = 1'b0;
        #1;
        while (!o_dmem_data_ok) begin
            @(negedge aclk);
            #1;
        end
        check_word("o_dmem_rdata", o_dmem_rdata, exp_data);
        check_word("dcache accepts", 32'(dc_model.accept_count - dc0), exp_unc ? 0 : 1);
        check_word("uncached accepts", 32'(unc_model.accept_count - un0), exp_unc ? 1 : 0);
    endtask

    // a store uses the same handshake, the slave drops the data
    task automatic store_check(input logic [`MMU_ADDR_W-1:0] va, input logic exp_unc,
                               input logic [`MMU_ADDR_W-1:0] exp_pa,
                               input logic [`MMU_DATA_W-1:0] wdata);
        @(negedge aclk);
        i_dmem_wr    = 1'b1;
        i_dmem_wdata = wdata;
        load_check(va, exp_unc, exp_pa, exp_pa ^ (exp_unc ? UNC_TAG : DC_TAG));
        @(negedge aclk);
        i_dmem_wr    = 1'b0;
        i_dmem_wdata = '0;
    endtask

    task automatic tlb_command(input tlb_op_e op, input logic [1:0] idx, input tlb_entry_t ent);
        @(negedge aclk);
        i_tlb_op    = op;
        i_tlb_index = idx;
        i_tlb_entry = ent;
        @(negedge aclk);
        i_tlb_op = TLB_NOP;
        #1;  // read and probe results are registered by now
    endtask

    task automatic kseg1_access();
        load_check(32'hA000_1000, 1'b1, 32'h0000_1000, 32'h0000_1000 ^ UNC_TAG);
        store_check(32'hA000_1004, 1'b1, 32'h0000_1004, 32'hDEAD_BEEF);
    endtask

    task automatic kseg0_routing();
        load_check(32'h8000_2000, 1'b0, 32'h0000_2000, 32'h0000_2000 ^ DC_TAG);
        store_check(32'h8000_2004, 1'b0, 32'h0000_2004, 32'h1357_9BDF);
        @(negedge aclk);
        i_k0_uncached = 1'b1;
        load_check(32'h8000_2000, 1'b1, 32'h0000_2000, 32'h0000_2000 ^ UNC_TAG);
        @(negedge aclk);
        i_k0_uncached = 1'b0;
    endtask

    task automatic tlb_operations();
        tlb_entry_t ent;
        ent.vpn      = 20'h00400;
        ent.pfn      = 20'h12345;
        ent.valid    = 1'b1;
        ent.uncached = 1'b0;
        tlb_command(TLB_WRITE, 2'd2, ent);
        tlb_command(TLB_READ, 2'd2, '0);
        check_entry("o_tlb_rd_entry", o_tlb_rd_entry, ent);
        tlb_command(TLB_PROBE, 2'd0, ent);
        check_flag("o_tlb_probe_hit", o_tlb_probe_hit, 1'b1);
        check_word("o_tlb_probe_index", 32'(o_tlb_probe_index), 32'd2);
        load_check(32'h0040_0ABC, 1'b0, 32'h1234_5ABC, 32'h1234_5ABC ^ DC_TAG);
    endtask

    task automatic tlb_miss();
        @(negedge aclk);
        i_dmem_req  = 1'b1;
        i_dmem_addr = 32'h0070_0120;  // kuseg page with no entry
        repeat (10) begin
            #1;
            check_flag("o_dmem_miss", o_dmem_miss, 1'b1);
            check_flag("o_dcache_req", o_dcache_req, 1'b0);
            check_flag("o_unc_req", o_unc_req, 1'b0);
            check_flag("o_dmem_addr_ok", o_dmem_addr_ok, 1'b0);
            @(negedge aclk);
        end
        i_dmem_req = 1'b0;
    endtask

    task automatic pipelined_traffic();
        logic [`MMU_DATA_W-1:0] exp_q[$];
        int unsigned dc0, un0;
        dc0 = dc_model.accept_count;
        un0 = unc_model.accept_count;
        fork
            begin
                logic [`MMU_ADDR_W-1:0] va;
                for (int i = 0; i < 20; i++) begin
                    va = (i % 2 == 0) ? 32'h8000_3000 + 32'(4 * i) : 32'hA000_4000 + 32'(4 * i);
                    issue_load(va);
                    exp_q.push_back(ref_rdata(va));
                end
                @(negedge aclk);
                i_dmem_req = 1'b0;
            end
            begin
                int got;
                got = 0;
                while (got < 20) begin
                    @(negedge aclk);
                    #1;
                    if (o_dmem_data_ok) begin
                        if (exp_q.size() == 0) begin
                            $display("data_ok arrived with no load outstanding at %0t", $time);
                            abort_run();
                        end
                        check_word("o_dmem_rdata", o_dmem_rdata, exp_q.pop_front());
                        got++;
                    end
                end
            end
        join
        check_word("dcache accepts", 32'(dc_model.accept_count - dc0), 32'd10);
        check_word("uncached accepts", 32'(unc_model.accept_count - un0), 32'd10);
    endtask

    task automatic instr_fetch();
        @(negedge aclk);
        i_imem_req  = 1'b1;
        i_imem_addr = 32'h9FC0_0000;
        #1;
        check_flag("o_imem_miss", o_imem_miss, 1'b0);
        check_flag("o_icache_req", o_icache_req, 1'b1);
        check_word("o_icache_addr", o_icache_addr, 32'h1FC0_0000);
        check_flag("o_imem_addr_ok", o_imem_addr_ok, 1'b1);
        @(negedge aclk);
        i_imem_req = 1'b0;
        #1;
        while (!o_imem_data_ok) begin
            @(negedge aclk);
            #1;
        end
        check_word("o_imem_rdata", o_imem_rdata, 32'h1FC0_0000 ^ IC_TAG);
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 200 * N_ACCESSES));
        $display("watchdog expired, the DUT stopped answering");
        abort_run();
    end

    initial begin
        aresetn       = 1'b1;
        i_k0_uncached = 1'b0;
        i_tlb_op      = TLB_NOP;
        i_tlb_index   = '0;
        i_tlb_entry   = '0;
        i_imem_req    = 1'b0;
        i_imem_addr   = '0;
        i_dmem_req    = 1'b0;
        i_dmem_wr     = 1'b0;
        i_dmem_addr   = '0;
        i_dmem_wdata  = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b0;
        kseg1_access();
        kseg0_routing();
        tlb_operations();
        tlb_miss();
        pipelined_traffic();
        instr_fetch();
        repeat (2) @(negedge aclk);
        $display("test passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hdl/mmu_pkg.sv
hdl/xlate_if.sv
hdl/dbus_if.sv
hdl/translation_unit.sv
hdl/dmem_dispatch.sv
hdl/mmu_top.sv
sim/mem_slave_model.sv
sim/mmu_tb.sv
